//--- hw/ol_defines.svh
// Output layer sizes and fixed-point format, included by every RTL and testbench file that needs them
`ifndef OL_DEFINES_SVH
`define OL_DEFINES_SVH

// Layer geometry
`define OL_P 8        // Neurons in the output layer
`define OL_Z 2        // Neurons handled per clock
`define OL_LAYERS 3   // Layers in the whole network

// Fixed point is sign + integer + fraction
`define OL_WIDTH 16
`define OL_INT_BITS 5
`define OL_FRAC_BITS 10

// Clocks per junction that carry data, also the lane memory depth
`define OL_DEPTH (`OL_P / `OL_Z)

// Two spare clocks per junction for memory latency
`define OL_CPC (`OL_DEPTH + 2)

// Ideal answers wait for the earlier junctions
`define OL_ANS_DELAY (`OL_CPC * (`OL_LAYERS - 1))

`endif

//--- hw/ol_pkg.sv
// Common types for the output layer blocks and testbench, taken in with a wildcard import
`include "ol_defines.svh"

package ol_pkg;

	// Activations and deltas share one signed format
	typedef logic signed [`OL_WIDTH-1:0] fix_t;

	// Clock index inside one junction cycle
	typedef logic [$clog2(`OL_CPC)-1:0] cyc_idx_t;

	// Word address into one lane memory
	typedef logic [$clog2(`OL_DEPTH)-1:0] mem_addr_t;

	// Delta FSM states
	typedef enum logic {
		SM_FIRST,  // First junction, nothing stored yet to read back
		SM_STEADY  // Previous junction's deltas are readable
	} sm_state_t;

endpackage

//--- hw/cycle_counter.sv
// Junction cycle counter that steps the output layer and exports its cycle index to the layer before
`timescale 1ns/1ps
`include "ol_defines.svh"

module cycle_counter
	import ol_pkg::*;
(
	input  logic     clk,
	input  logic     reset_i,
	output cyc_idx_t cycle_idx_o, // Clock index within the junction
	output logic     wrap_o       // High on the last clock of the junction
);

	localparam cyc_idx_t LAST_IDX = cyc_idx_t'(`OL_CPC - 1);

	// Modulo OL_CPC count, starts at 0 on the first clock out of reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			cycle_idx_o <= '0;
		end else if (wrap_o) begin
			cycle_idx_o <= '0; // Back to the start of the next junction
		end else begin
			cycle_idx_o <= cycle_idx_o + 1'b1;
		end
	end

	assign wrap_o = (cycle_idx_o == LAST_IDX); // Reset holds the count at 0 so this stays low

	// Count must wrap before it leaves the junction
	a_idx_range: assert property (
		@(posedge clk) disable iff (reset_i)
		cycle_idx_o < cyc_idx_t'(`OL_CPC)
	);

endmodule

//--- hw/delta_sm.sv
// Delta memory FSM that drives ping-pong collection pointers, addresses and read-valid
`timescale 1ns/1ps
`include "ol_defines.svh"

module delta_sm
	import ol_pkg::*;
(
	input  logic      clk,
	input  logic      reset_i,
	input  cyc_idx_t  cycle_idx_i, // Clock index within the junction
	input  logic      wrap_i,      // Last clock of the junction
	output logic      wr_coll_o,   // Collection filled in this junction
	output mem_addr_t wr_addr_o,
	output logic      wr_en_o,
	output logic      rd_coll_o,   // Collection holding the previous junction
	output mem_addr_t rd_addr_o,
	output logic      del_valid_o  // Lines up with the synchronous read data
);

	localparam cyc_idx_t DATA_CLKS = cyc_idx_t'(`OL_DEPTH);

	sm_state_t state_q;
	sm_state_t state_d;
	logic      data_clk; // Clock carries activations

	// Only the first OL_DEPTH clocks of a junction carry data
	assign data_clk = (cycle_idx_i < DATA_CLKS);

	// Leave SM_FIRST once a whole junction has been stored
	always_comb begin
		state_d = state_q;
		case (state_q)
			SM_FIRST: begin
				if (wrap_i) begin
					state_d = SM_STEADY;
				end
			end
			SM_STEADY: state_d = SM_STEADY; // Stays until reset
			default: state_d = SM_FIRST;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q     <= SM_FIRST;
			wr_coll_o   <= 1'b0; // First junction fills collection 0
			del_valid_o <= 1'b0;
		end else begin
			state_q <= state_d;
			if (wrap_i) begin
				wr_coll_o <= ~wr_coll_o; // Swap roles at every junction boundary
			end
			// Read issued at index k returns at k+1
			del_valid_o <= data_clk && (state_q == SM_STEADY);
		end
	end

	// Write and read walk the same address as the clock index
	assign wr_en_o   = data_clk;
	assign wr_addr_o = mem_addr_t'(cycle_idx_i);
	assign rd_addr_o = mem_addr_t'(cycle_idx_i);
	assign rd_coll_o = ~wr_coll_o; // Always the other collection

	// Collection just filled is the one read back in the next junction
	a_coll_split: assert property (
		@(posedge clk) disable iff (reset_i)
		wrap_i |=> (rd_coll_o == $past(wr_coll_o))
	);

	// Nothing leaves before one full junction is stored
	a_no_valid_first: assert property (
		@(posedge clk) disable iff (reset_i)
		(state_q == SM_FIRST) |-> !del_valid_o
	);

endmodule

//--- hw/delta_mem_bank.sv
// Two collections of lane memories that hold the deltas of the current and the previous junction
`timescale 1ns/1ps
`include "ol_defines.svh"

module delta_mem_bank
	import ol_pkg::*;
(
	input  logic                clk,
	input  logic                wr_coll_i, // Collection to write
	input  mem_addr_t           wr_addr_i,
	input  logic                wr_en_i,
	input  fix_t [`OL_Z-1:0]    wr_data_i, // One delta per lane
	input  logic                rd_coll_i, // Collection to read
	input  mem_addr_t           rd_addr_i,
	output fix_t [`OL_Z-1:0]    rd_data_o  // Valid one clock after the address
);

	fix_t rd_q [2][`OL_Z]; // Read registers of every lane memory
	logic rd_coll_q;       // Select follows the read by one clock

	genvar gc;
	genvar gl;
	generate
		for (gc = 0; gc < 2; gc++) begin : g_coll
			for (gl = 0; gl < `OL_Z; gl++) begin : g_lane
				fix_t mem [`OL_DEPTH]; // One lane memory
				logic we;

				assign we = wr_en_i && (wr_coll_i == 1'(gc));

				// Single-port style write, read every clock
				always_ff @(posedge clk) begin
					if (we) begin
						mem[wr_addr_i] <= wr_data_i[gl];
					end
					rd_q[gc][gl] <= mem[rd_addr_i];
				end
			end
		end
	endgenerate

	always_ff @(posedge clk) begin
		rd_coll_q <= rd_coll_i;
	end

	// Pick the collection that was addressed last clock
	always_comb begin
		for (int j = 0; j < `OL_Z; j++) begin
			rd_data_o[j] = rd_q[rd_coll_q][j];
		end
	end

endmodule

//--- hw/cost_term_set.sv
// Per-lane cross-entropy delta, activation minus the ideal answer in fixed point
`timescale 1ns/1ps
`include "ol_defines.svh"

module cost_term_set
	import ol_pkg::*;
(
	input  fix_t [`OL_Z-1:0]  act_i, // Sigmoid activations from the layer before
	input  logic [`OL_Z-1:0]  ans_i, // Delayed one-bit ideal answers
	output fix_t [`OL_Z-1:0]  del_o  // Deltas to the memory bank
);

	// 1.0 in fixed point, sign and upper integer bits clear
	localparam fix_t FIX_ONE = {
		1'b0,
		{(`OL_INT_BITS-1){1'b0}},
		1'b1,
		{`OL_FRAC_BITS{1'b0}}
	};

	genvar gl;
	generate
		for (gl = 0; gl < `OL_Z; gl++) begin : g_lane
			fix_t ideal; // Answer bit widened to fixed point

			assign ideal = ans_i[gl] ? FIX_ONE : '0;

			// Cross-entropy with sigmoid needs no derivative term
			assign del_o[gl] = act_i[gl] - ideal; // Wraps, no saturation
		end
	endgenerate

endmodule

//--- hw/ideal_ans_delay.sv
// Shift register that holds the ideal answers until their activations reach the output layer
`timescale 1ns/1ps
`include "ol_defines.svh"

module ideal_ans_delay (
	input  logic              clk,
	input  logic              reset_i,
	input  logic [`OL_Z-1:0]  ans_i, // Answers given with the network inputs
	output logic [`OL_Z-1:0]  ans_o  // Same answers OL_ANS_DELAY clocks later
);

	logic [`OL_Z-1:0] sr_q [`OL_ANS_DELAY]; // One stage per clock of latency

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `OL_ANS_DELAY; i++) begin
				sr_q[i] <= '0; // Output reads zero until the pipe refills
			end
		end else begin
			sr_q[0] <= ans_i;
			for (int i = 1; i < `OL_ANS_DELAY; i++) begin
				sr_q[i] <= sr_q[i-1];
			end
		end
	end

	assign ans_o = sr_q[`OL_ANS_DELAY-1];

endmodule

//--- hw/output_layer.sv
// Output layer top, computes and stores deltas and hands the previous junction's deltas back
`timescale 1ns/1ps
`include "ol_defines.svh"

module output_layer
	import ol_pkg::*;
(
	input  logic              clk,
	input  logic              reset_i,
	input  fix_t [`OL_Z-1:0]  act_i,         // Activations, one neuron per lane
	input  logic [`OL_Z-1:0]  ans_i,         // Ideal answers from the network input
	output fix_t [`OL_Z-1:0]  del_o,         // Deltas to the layer before
	output logic              del_valid_o,
	output logic [`OL_Z-1:0]  ans_o,         // Delayed ideal answers
	output cyc_idx_t          cycle_index_o, // Keeps the layer before in step
	output logic              cycle_clk_o    // Last clock of each junction
);

	logic             wr_coll;
	logic             wr_en;
	logic             rd_coll;
	mem_addr_t        wr_addr;
	mem_addr_t        rd_addr;
	fix_t [`OL_Z-1:0] del_wr; // Fresh deltas into the bank

	cycle_counter u_cycle_counter (
		.clk         (clk),
		.reset_i     (reset_i),
		.cycle_idx_o (cycle_index_o),
		.wrap_o      (cycle_clk_o)
	);

	delta_sm u_delta_sm (
		.clk         (clk),
		.reset_i     (reset_i),
		.cycle_idx_i (cycle_index_o),
		.wrap_i      (cycle_clk_o),
		.wr_coll_o   (wr_coll),
		.wr_addr_o   (wr_addr),
		.wr_en_o     (wr_en),
		.rd_coll_o   (rd_coll),
		.rd_addr_o   (rd_addr),
		.del_valid_o (del_valid_o)
	);

	ideal_ans_delay u_ans_delay (
		.clk     (clk),
		.reset_i (reset_i),
		.ans_i   (ans_i),
		.ans_o   (ans_o)
	);

	// Delayed answers meet their activations here
	cost_term_set u_cost_terms (
		.act_i (act_i),
		.ans_i (ans_o),
		.del_o (del_wr)
	);

	delta_mem_bank u_del_mem (
		.clk       (clk),
		.wr_coll_i (wr_coll),
		.wr_addr_i (wr_addr),
		.wr_en_i   (wr_en),
		.wr_data_i (del_wr),
		.rd_coll_i (rd_coll),
		.rd_addr_i (rd_addr),
		.rd_data_o (del_o)
	);

endmodule

//--- tb/tb_output_layer.sv
// Directed testbench for the output layer top, compiled from src.f and run by run_sim.sh
`timescale 1ns/1ps
`include "ol_defines.svh"

module tb_output_layer
	import ol_pkg::*;
();

	localparam fix_t FIX_ONE = fix_t'(1 << `OL_FRAC_BITS); // Ideal answer 1.0
	localparam int TIMEOUT_CYCLES = 5 * 10 * `OL_CPC + 100; // Ten junctions per test plus margin

	logic             clk = 1'b0;
	logic             reset_i;
	fix_t [`OL_Z-1:0] act_i;
	logic [`OL_Z-1:0] ans_i;
	fix_t [`OL_Z-1:0] del_o;
	logic             del_valid_o;
	logic [`OL_Z-1:0] ans_o;
	cyc_idx_t         cycle_index_o;
	logic             cycle_clk_o;

	// Reference model state
	int               exp_idx;                    // Expected cycle index of the current clock
	int               junc;                       // Junctions since reset
	logic [`OL_Z-1:0] ans_q [$];                  // Answers sent, oldest first
	fix_t             cur_del [`OL_DEPTH][`OL_Z]; // Deltas of this junction
	fix_t             prev_del [`OL_DEPTH][`OL_Z];
	int               valid_count;                // del_valid_o clocks seen
	logic [15:0]      lfsr_q = 16'd24;

	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;

	output_layer dut0 (
		.clk           (clk),
		.reset_i       (reset_i),
		.act_i         (act_i),
		.ans_i         (ans_i),
		.del_o         (del_o),
		.del_valid_o   (del_valid_o),
		.ans_o         (ans_o),
		.cycle_index_o (cycle_index_o),
		.cycle_clk_o   (cycle_clk_o)
	);

	always #20 clk = ~clk; // 40 ns period

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// 16-bit Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q); // One step per bit
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Sigmoid range activations and answer bits for one clock
	task automatic random_inputs(output fix_t [`OL_Z-1:0] act, output logic [`OL_Z-1:0] ans);
		logic [31:0] r;
		for (int j = 0; j < `OL_Z; j++) begin
			get_bits(`OL_FRAC_BITS, r);
			act[j] = fix_t'(r[`OL_FRAC_BITS-1:0]); // 0 up to just under 1.0
			get_bits(1, r);
			ans[j] = r[0];
		end
	endtask

	// Enters at a rising edge, holds reset for 5 cycles, leaves at the releasing edge
	task automatic apply_reset();
		reset_i <= 1'b1;
		act_i   <= '0;
		ans_i   <= '0;
		repeat (5) @(posedge clk);
		reset_i <= 1'b0;
		exp_idx = 0;
		junc    = 0;
		ans_q.delete();
	endtask

	// Drives one clock, checks every output against the model, ends at the next edge
	task automatic run_clock(input fix_t [`OL_Z-1:0] act, input logic [`OL_Z-1:0] ans);
		logic [`OL_Z-1:0] exp_ans;
		logic             exp_valid;
		act_i <= act;
		ans_i <= ans;
		ans_q.push_back(ans);
		if (ans_q.size() > `OL_ANS_DELAY) begin
			exp_ans = ans_q.pop_front(); // Sent OL_ANS_DELAY clocks ago
		end else begin
			exp_ans = '0; // Pipe still empty after reset
		end
		if (exp_idx < `OL_DEPTH) begin
			for (int j = 0; j < `OL_Z; j++) begin
				cur_del[exp_idx][j] = act[j] - (exp_ans[j] ? FIX_ONE : fix_t'(0));
			end
		end
		exp_valid = (junc > 0) && (exp_idx >= 1) && (exp_idx <= `OL_DEPTH);
		@(negedge clk); // Outputs settled
		compare_value("cycle_index_o", 32'(cycle_index_o), 32'(exp_idx));
		compare_value("cycle_clk_o", 32'(cycle_clk_o), 32'(exp_idx == `OL_CPC - 1));
		compare_value("ans_o", 32'(ans_o), 32'(exp_ans));
		compare_value("del_valid_o", 32'(del_valid_o), 32'(exp_valid));
		valid_count += int'(del_valid_o);
		if (exp_valid) begin
			for (int j = 0; j < `OL_Z; j++) begin
				compare_value($sformatf("del_o[%0d]", j), 32'(del_o[j]),
					32'(prev_del[exp_idx-1][j])); // Entry k of last junction at k+1
			end
		end
		if (exp_idx == `OL_CPC - 1) begin
			exp_idx  = 0;
			junc++;
			prev_del = cur_del; // Ping-pong swap
		end else begin
			exp_idx++;
		end
		@(posedge clk);
	endtask

	task automatic counter_after_reset();
		@(posedge clk);
		reset_i <= 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		compare_value("cycle_clk_o", 32'(cycle_clk_o), 32'd0); // Low while in reset
		compare_value("del_valid_o", 32'(del_valid_o), 32'd0);
		@(posedge clk);
		apply_reset();
		repeat (3 * `OL_CPC) run_clock('0, '0);
	endtask

	task automatic answer_delay_stream();
		fix_t [`OL_Z-1:0] act;
		logic [`OL_Z-1:0] ans;
		apply_reset();
		repeat (6 * `OL_CPC) begin
			random_inputs(act, ans);
			run_clock(act, ans);
		end
	endtask

	// Walks 0, 0.25 .. 1.0 against both answer values
	task automatic delta_directed_values();
		fix_t [`OL_Z-1:0] act;
		logic [`OL_Z-1:0] ans;
		apply_reset();
		for (int n = 0; n < 5 * `OL_CPC; n++) begin
			for (int j = 0; j < `OL_Z; j++) begin
				act[j] = fix_t'(((n + j) % 5) * 256);
				ans[j] = ((n + j) % 2) == 1; // Lines up with act after the answer delay
			end
			run_clock(act, ans);
		end
	endtask

	task automatic ping_pong_junctions();
		fix_t [`OL_Z-1:0] act;
		logic [`OL_Z-1:0] ans;
		apply_reset();
		repeat (6 * `OL_CPC) begin
			random_inputs(act, ans);
			run_clock(act, ans);
		end
	endtask

	task automatic valid_window_per_junction();
		fix_t [`OL_Z-1:0] act;
		logic [`OL_Z-1:0] ans;
		apply_reset();
		for (int jn = 0; jn < 4; jn++) begin
			valid_count = 0;
			repeat (`OL_CPC) begin
				random_inputs(act, ans);
				run_clock(act, ans);
			end
			compare_value("del_valid_o count", 32'(valid_count),
				32'((jn == 0) ? 0 : `OL_DEPTH)); // None in the first junction
		end
	endtask

	initial begin
		reset_i = 1'b1;
		act_i   = '0;
		ans_i   = '0;
		valid_count = 0;
		@(posedge clk);
		counter_after_reset();
		answer_delay_stream();
		delta_directed_values();
		ping_pong_junctions();
		valid_window_per_junction();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+hw
hw/ol_pkg.sv
hw/cycle_counter.sv
hw/delta_sm.sv
hw/delta_mem_bank.sv
hw/cost_term_set.sv
hw/ideal_ans_delay.sv
hw/output_layer.sv
tb/tb_output_layer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the output layer testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

TOP=tb_output_layer
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--top-module "$TOP" \
	-Mdir "$OBJ_DIR" \
	-f src.f

rm -f "$LOG"
"./$OBJ_DIR/V$TOP" | tee "$LOG"

if grep -qx "TESTS PASSED" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
